// File: hdl/cvxif_consts.svh
// CV-X-IF offload path constants
// Widths, custom-0 decode values, MUL latency and queue depths
`ifndef CVXIF_CONSTS_SVH
`define CVXIF_CONSTS_SVH

// Operand, result and id widths
`define XLEN 32
`define ID_W 4

// Custom-0 major opcode, the only one the coprocessor takes
`define OPC_CUSTOM0 7'b0001011

// Accepted funct3 codes
`define F3_ADD 3'd0
`define F3_XOR 3'd1
`define F3_MUL 3'd2
`define F3_SUB 3'd3

`define MUL_CYCLES 4
`define RES_DEPTH  2
`define REJ_DEPTH  2

// Illegal instruction cause
`define EXC_ILLEGAL 2

`endif

// File: hdl/cvxif_pkg.sv
// CV-X-IF offload path types
// Transaction id, coprocessor result record and refusal record
`include "cvxif_consts.svh"

package cvxif_pkg;

  // Transaction id shared by issue, commit and writeback
  typedef logic [`ID_W-1:0] id_t;

  // One coprocessor result waiting for writeback
  typedef struct packed {
    id_t              id;
    logic [`XLEN-1:0] data;
    logic             we;
  } xresult_t;

  // One refused instruction, reported later as an illegal instruction
  typedef struct packed {
    id_t         id;
    logic [31:0] instr;
  } xreject_t;

endpackage

// File: hdl/hold_buf.sv
// Small circular FIFO for records of any packed type
// Takes up to two pushes per cycle, the push_i entry going first,
// and shows its head as a valid level plus the record
`timescale 1ns/1ps

module hold_buf #(
  parameter type T = logic,
  parameter int DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  input  logic push2_i,
  input  T     data2_i,
  input  logic pop_i,
  output logic valid_o,
  output T     data_o,
  output logic full_o,
  output logic space2_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int PW = AW + 1;
  localparam int CW = $clog2(DEPTH + 1);

  T mem [DEPTH];

  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AW-1:0] slot2;
  logic [CW-1:0] cnt_q;
  logic          do_pop;

  // Pointer advance with wrap at DEPTH
  function automatic logic [AW-1:0] ptr_add(input logic [AW-1:0] p, input logic [1:0] n);
    logic [PW-1:0] sum;
    sum = {1'b0, p} + PW'(n);
    if (sum >= PW'(DEPTH)) begin
      sum = sum - PW'(DEPTH);
    end
    return sum[AW-1:0];
  endfunction

  assign valid_o  = (cnt_q != '0);
  assign data_o   = mem[rd_ptr_q];
  assign full_o   = (int'(cnt_q) == DEPTH);
  assign space2_o = (int'(cnt_q) + 2 <= DEPTH);

  // Popping an empty buffer does nothing
  assign do_pop = pop_i & valid_o;

  // Second entry lands behind the first when both arrive
  assign slot2 = push_i ? ptr_add(wr_ptr_q, 2'd1) : wr_ptr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= ptr_add(wr_ptr_q, {1'b0, push_i} + {1'b0, push2_i});
      if (do_pop) begin
        rd_ptr_q <= ptr_add(rd_ptr_q, 2'd1);
      end
      cnt_q <= cnt_q + CW'(push_i) + CW'(push2_i) - CW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
    if (push2_i) begin
      mem[slot2] <= data2_i;
    end
  end

endmodule

// File: hdl/cvxif_offload.sv
// Core-side CV-X-IF functional unit
// Forwards each offloaded instruction as issue and commit to the
// coprocessor and keeps a record of every refused instruction
`timescale 1ns/1ps
`include "cvxif_consts.svh"

module cvxif_offload (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // From the issue stage
  input  logic                  x_valid_i,
  output logic                  x_ready_o,
  input  logic [31:0]           x_instr_i,
  input  cvxif_pkg::id_t        x_id_i,
  input  logic [`XLEN-1:0]      x_rs1_i,
  input  logic [`XLEN-1:0]      x_rs2_i,
  // To the coprocessor
  output logic                  issue_valid_o,
  input  logic                  issue_ready_i,
  input  logic                  issue_accept_i,
  output logic [31:0]           issue_instr_o,
  output cvxif_pkg::id_t        issue_id_o,
  output logic [`XLEN-1:0]      issue_rs1_o,
  output logic [`XLEN-1:0]      issue_rs2_o,
  output logic                  commit_valid_o,
  // Pending refusals towards the writeback merge
  output logic                  rej_valid_o,
  output cvxif_pkg::xreject_t   rej_o,
  input  logic                  rej_pop_i
);

  logic                rej_full;
  logic                rej_push;
  cvxif_pkg::xreject_t rej_rec;

  // No new issue while a refusal could not be recorded
  assign issue_valid_o  = x_valid_i & ~rej_full;
  assign x_ready_o      = issue_ready_i & ~rej_full;
  assign commit_valid_o = issue_valid_o;

  assign issue_instr_o = x_instr_i;
  assign issue_id_o    = x_id_i;
  assign issue_rs1_o   = x_rs1_i;
  assign issue_rs2_o   = x_rs2_i;

  // Handshake completed but the coprocessor said no
  assign rej_push      = issue_valid_o & issue_ready_i & ~issue_accept_i;
  assign rej_rec.id    = x_id_i;
  assign rej_rec.instr = x_instr_i;

  hold_buf #(
    .T     (cvxif_pkg::xreject_t),
    .DEPTH (`REJ_DEPTH)
  ) u_rej_buf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (rej_push),
    .data_i   (rej_rec),
    .push2_i  (1'b0),
    .data2_i  ('0),
    .pop_i    (rej_pop_i),
    .valid_o  (rej_valid_o),
    .data_o   (rej_o),
    .full_o   (rej_full),
    .space2_o ()
  );

endmodule

// File: hdl/xcopro.sv
// Custom-0 coprocessor on the CV-X-IF issue and commit signals
// Accepts ADD, XOR and SUB (one cycle) and MUL (MUL_CYCLES cycles),
// refuses everything else, and queues results for writeback
`timescale 1ns/1ps
`include "cvxif_consts.svh"

module xcopro (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  output logic                  issue_accept_o,
  input  logic [31:0]           issue_instr_i,
  input  cvxif_pkg::id_t        issue_id_i,
  input  logic [`XLEN-1:0]      issue_rs1_i,
  input  logic [`XLEN-1:0]      issue_rs2_i,
  input  logic                  commit_valid_i,
  output logic                  res_valid_o,
  output cvxif_pkg::xresult_t   res_o,
  input  logic                  res_pop_i
);

  localparam int CNT_W = $clog2(`MUL_CYCLES);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                is_mul;
  logic                fire;
  logic                fire_single;
  logic                fire_mul;
  logic [`XLEN-1:0]    alu_res;
  logic                mul_busy_q;
  logic [CNT_W-1:0]    mul_cnt_q;
  logic [`XLEN-1:0]    mul_a_q, mul_b_q;
  cvxif_pkg::id_t      mul_id_q;
  logic                mul_done;
  logic                res_full;
  logic                res_space2;
  cvxif_pkg::xresult_t single_rec, mul_rec;

  // Decode
  assign opcode = issue_instr_i[6:0];
  assign funct3 = issue_instr_i[14:12];
  assign is_mul = (funct3 == `F3_MUL);

  assign issue_accept_o = (opcode == `OPC_CUSTOM0) &&
                          (funct3 inside {`F3_ADD, `F3_XOR, `F3_MUL, `F3_SUB});

  // Work starts once issue and commit come together
  assign fire        = issue_valid_i & commit_valid_i & issue_ready_o;
  assign fire_single = fire & issue_accept_o & ~is_mul;
  assign fire_mul    = fire & issue_accept_o & is_mul;

  always_comb begin
    case (funct3)
      `F3_ADD: alu_res = issue_rs1_i + issue_rs2_i;
      `F3_XOR: alu_res = issue_rs1_i ^ issue_rs2_i;
      `F3_SUB: alu_res = issue_rs1_i - issue_rs2_i;
      default: alu_res = '0;
    endcase
  end

  assign single_rec.id   = issue_id_i;
  assign single_rec.data = alu_res;
  assign single_rec.we   = 1'b1;

  // MUL stage finishes on the last count, waiting if the queue is full
  assign mul_done = mul_busy_q && (mul_cnt_q == CNT_W'(1)) && !res_full;

  assign mul_rec.id   = mul_id_q;
  assign mul_rec.data = mul_a_q * mul_b_q;
  assign mul_rec.we   = 1'b1;

  // While MUL runs, ready only opens in its last cycle, and then
  // the queue must hold both the MUL and a single-cycle result
  assign issue_ready_o = mul_busy_q ? (mul_done & res_space2) : ~res_full;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mul_busy_q <= 1'b0;
      mul_cnt_q  <= '0;
    end else if (fire_mul) begin
      mul_busy_q <= 1'b1;
      mul_cnt_q  <= CNT_W'(`MUL_CYCLES - 1);
    end else if (mul_done) begin
      mul_busy_q <= 1'b0;
    end else if (mul_busy_q && mul_cnt_q != CNT_W'(1)) begin
      mul_cnt_q <= mul_cnt_q - CNT_W'(1);
    end
  end

  // Operands and id held for the whole multiply
  always_ff @(posedge clk_i) begin
    if (fire_mul) begin
      mul_a_q  <= issue_rs1_i;
      mul_b_q  <= issue_rs2_i;
      mul_id_q <= issue_id_i;
    end
  end

  hold_buf #(
    .T     (cvxif_pkg::xresult_t),
    .DEPTH (`RES_DEPTH)
  ) u_res_buf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (mul_done),
    .data_i   (mul_rec),
    .push2_i  (fire_single),
    .data2_i  (single_rec),
    .pop_i    (res_pop_i),
    .valid_o  (res_valid_o),
    .data_o   (res_o),
    .full_o   (res_full),
    .space2_o (res_space2)
  );

endmodule

// File: hdl/cvxif_wb_merge.sv
// Writeback merge for the offload path
// Coprocessor results go first; a pending refusal goes out as an
// illegal-instruction exception when no result is waiting
`timescale 1ns/1ps
`include "cvxif_consts.svh"

module cvxif_wb_merge (
  input  logic                  res_valid_i,
  input  cvxif_pkg::xresult_t   res_i,
  input  logic                  rej_valid_i,
  input  cvxif_pkg::xreject_t   rej_i,
  output logic                  res_pop_o,
  output logic                  rej_pop_o,
  output logic                  x_valid_o,
  output cvxif_pkg::id_t        x_id_o,
  output logic [`XLEN-1:0]      x_result_o,
  output logic                  x_we_o,
  output logic                  x_exc_valid_o,
  output logic [`XLEN-1:0]      x_exc_cause_o,
  output logic [`XLEN-1:0]      x_exc_tval_o
);

  // The writeback always takes what is shown, so pop in the same cycle
  assign res_pop_o = res_valid_i;
  assign rej_pop_o = rej_valid_i & ~res_valid_i;

  always_comb begin
    x_valid_o     = 1'b0;
    x_id_o        = '0;
    x_result_o    = '0;
    x_we_o        = 1'b0;
    x_exc_valid_o = 1'b0;
    x_exc_cause_o = '0;
    x_exc_tval_o  = '0;
    if (res_valid_i) begin
      x_valid_o  = 1'b1;
      x_id_o     = res_i.id;
      x_result_o = res_i.data;
      x_we_o     = res_i.we;
    end else if (rej_valid_i) begin
      x_valid_o     = 1'b1;
      x_id_o        = rej_i.id;
      x_exc_valid_o = 1'b1;
      x_exc_cause_o = `XLEN'(`EXC_ILLEGAL);
      // Faulting instruction word as trap value
      x_exc_tval_o  = `XLEN'(rej_i.instr);
    end
  end

endmodule

// File: hdl/cvxif_subsys.sv
// CV-X-IF offload subsystem
// Offload unit and custom-0 coprocessor share the issue signals,
// the writeback merge turns their outputs into one writeback stream
`timescale 1ns/1ps
`include "cvxif_consts.svh"

module cvxif_subsys (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Issue side
  input  logic                  x_valid_i,
  output logic                  x_ready_o,
  input  logic [31:0]           x_instr_i,
  input  cvxif_pkg::id_t        x_id_i,
  input  logic [`XLEN-1:0]      x_rs1_i,
  input  logic [`XLEN-1:0]      x_rs2_i,
  // Writeback side
  output logic                  x_valid_o,
  output cvxif_pkg::id_t        x_id_o,
  output logic [`XLEN-1:0]      x_result_o,
  output logic                  x_we_o,
  output logic                  x_exc_valid_o,
  output logic [`XLEN-1:0]      x_exc_cause_o,
  output logic [`XLEN-1:0]      x_exc_tval_o
);

  logic                issue_valid;
  logic                issue_ready;
  logic                issue_accept;
  logic [31:0]         issue_instr;
  cvxif_pkg::id_t      issue_id;
  logic [`XLEN-1:0]    issue_rs1, issue_rs2;
  logic                commit_valid;
  logic                rej_valid, rej_pop;
  cvxif_pkg::xreject_t rej;
  logic                res_valid, res_pop;
  cvxif_pkg::xresult_t res;

  cvxif_offload u_offload (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .x_valid_i      (x_valid_i),
    .x_ready_o      (x_ready_o),
    .x_instr_i      (x_instr_i),
    .x_id_i         (x_id_i),
    .x_rs1_i        (x_rs1_i),
    .x_rs2_i        (x_rs2_i),
    .issue_valid_o  (issue_valid),
    .issue_ready_i  (issue_ready),
    .issue_accept_i (issue_accept),
    .issue_instr_o  (issue_instr),
    .issue_id_o     (issue_id),
    .issue_rs1_o    (issue_rs1),
    .issue_rs2_o    (issue_rs2),
    .commit_valid_o (commit_valid),
    .rej_valid_o    (rej_valid),
    .rej_o          (rej),
    .rej_pop_i      (rej_pop)
  );

  xcopro u_copro (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid),
    .issue_ready_o  (issue_ready),
    .issue_accept_o (issue_accept),
    .issue_instr_i  (issue_instr),
    .issue_id_i     (issue_id),
    .issue_rs1_i    (issue_rs1),
    .issue_rs2_i    (issue_rs2),
    .commit_valid_i (commit_valid),
    .res_valid_o    (res_valid),
    .res_o          (res),
    .res_pop_i      (res_pop)
  );

  cvxif_wb_merge u_merge (
    .res_valid_i   (res_valid),
    .res_i         (res),
    .rej_valid_i   (rej_valid),
    .rej_i         (rej),
    .res_pop_o     (res_pop),
    .rej_pop_o     (rej_pop),
    .x_valid_o     (x_valid_o),
    .x_id_o        (x_id_o),
    .x_result_o    (x_result_o),
    .x_we_o        (x_we_o),
    .x_exc_valid_o (x_exc_valid_o),
    .x_exc_cause_o (x_exc_cause_o),
    .x_exc_tval_o  (x_exc_tval_o)
  );

endmodule

// File: tests/tb_clock.sv
// Testbench clock and reset generator
// Free-running clock, reset held low for a fixed number of cycles
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release just after a rising edge, like the other inputs
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// File: tests/cvxif_checker.sv
// Concurrent assertions on the offload subsystem writeback ports
`timescale 1ns/1ps
`include "cvxif_consts.svh"

module cvxif_checker (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             valid_i,
  input cvxif_pkg::id_t   id_i,
  input logic             we_i,
  input logic             exc_valid_i,
  input logic [`XLEN-1:0] cause_i
);

  // A refused instruction never writes back and always has the illegal cause
  exc_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && exc_valid_i) |-> (!we_i && cause_i == `XLEN'(`EXC_ILLEGAL)))
    else $error("exception writeback with write enable or a wrong cause");

  exc_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exc_valid_i |-> valid_i)
    else $error("exception flagged without a valid writeback");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!valid_i && !exc_valid_i && !we_i))
    else $error("writeback outputs active during reset");

  id_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> !$isunknown(id_i))
    else $error("writeback id has unknown bits");

endmodule

// File: tests/cvxif_tb.sv
// Directed testbench for the CV-X-IF offload subsystem
// Keeps an expected writeback per id from its own decode and ALU model
`timescale 1ns/1ps
`include "cvxif_consts.svh"

module cvxif_tb;

  localparam int NUM_IDS    = 2 ** `ID_W;
  localparam int STREAM_LEN = 200;
  localparam int WAIT_LIMIT = 40;
  // Twice the directed waits at their limit plus a slow stream
  localparam int WATCHDOG_CYCLES =
    2 * (16 + 10 * WAIT_LIMIT + STREAM_LEN * (`MUL_CYCLES + 2)) + 100;

  logic                clk_i;
  logic                rst_ni;
  logic                x_valid_i;
  logic                x_ready_o;
  logic [31:0]         x_instr_i;
  cvxif_pkg::id_t      x_id_i;
  logic [`XLEN-1:0]    x_rs1_i;
  logic [`XLEN-1:0]    x_rs2_i;
  logic                x_valid_o;
  cvxif_pkg::id_t      x_id_o;
  logic [`XLEN-1:0]    x_result_o;
  logic                x_we_o;
  logic                x_exc_valid_o;
  logic [`XLEN-1:0]    x_exc_cause_o;
  logic [`XLEN-1:0]    x_exc_tval_o;

  // Expected writeback per id
  // An id is outstanding while issued differs from done
  logic                exp_exc [NUM_IDS];
  logic [`XLEN-1:0]    exp_data [NUM_IDS];
  logic [31:0]         exp_tval [NUM_IDS];
  int                  issued [NUM_IDS];
  int                  done [NUM_IDS];
  int                  issue_cyc [NUM_IDS];
  int                  seen_cyc [NUM_IDS];
  int                  cyc;
  int                  wb_cnt;
  int                  mon_err;
  int                  tst_err;
  int                  errs_start;
  logic [31:0]         rnd;

  tb_clock u_clock (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  cvxif_subsys DUT (.*);

  bind cvxif_subsys cvxif_checker u_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (x_valid_o),
    .id_i        (x_id_o),
    .we_i        (x_we_o),
    .exc_valid_i (x_exc_valid_o),
    .cause_i     (x_exc_cause_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // rd = x3, rs1 = x1, rs2 = x2
  function automatic logic [31:0] make_instr(input logic [6:0] opc, input logic [2:0] f3);
    return {7'h00, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic is_accepted(input logic [31:0] instr);
    return (instr[6:0] == 7'b0001011) && (instr[14:12] <= 3'd3);
  endfunction

  function automatic logic [`XLEN-1:0] op_result(input logic [31:0] instr,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    case (instr[14:12])
      3'd0: return a + b;
      3'd1: return a ^ b;
      3'd2: return a * b;
      3'd3: return a - b;
      default: return '0;
    endcase
  endfunction

  function automatic int mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
    mismatch = 0;
    assert (got == exp) else begin
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      mismatch = 1;
    end
  endfunction

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // Outputs are sampled mid-cycle where they have settled
  always @(negedge clk_i) begin : wb_monitor
    cvxif_pkg::id_t id;
    logic           exc;
    if (rst_ni && x_valid_o) begin
      id  = x_id_o;
      exc = exp_exc[id];
      assert (issued[id] != done[id]) else begin
        $display("Unexpected writeback at %0t for id %0d with nothing outstanding",
                 $time, id);
        mon_err++;
      end
      mon_err += mismatch("x_exc_valid_o", 32'(x_exc_valid_o), 32'(exc));
      mon_err += mismatch("x_we_o", 32'(x_we_o), 32'(!exc));
      mon_err += mismatch("x_result_o", x_result_o, exc ? 32'd0 : exp_data[id]);
      mon_err += mismatch("x_exc_cause_o", x_exc_cause_o, exc ? 32'd2 : 32'd0);
      mon_err += mismatch("x_exc_tval_o", x_exc_tval_o, exc ? exp_tval[id] : 32'd0);
      done[id]     = done[id] + 1;
      seen_cyc[id] = cyc;
      wb_cnt++;
    end
  end

  task automatic wait_idle(input cvxif_pkg::id_t id);
    int n;
    n = 0;
    while (issued[id] != done[id] && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    assert (issued[id] == done[id]) else begin
      $display("No writeback for id %0d within %0d cycles", id, WAIT_LIMIT);
      tst_err++;
    end
  endtask

  // Returns one cycle after the issue edge with the inputs idle again
  task automatic issue_op(input cvxif_pkg::id_t id, input logic [31:0] instr,
                          input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    wait_idle(id);
    exp_exc[id]  = !is_accepted(instr);
    exp_data[id] = op_result(instr, a, b);
    exp_tval[id] = instr;
    x_valid_i = 1'b1;
    x_instr_i = instr;
    x_id_i    = id;
    x_rs1_i   = a;
    x_rs2_i   = b;
    while (!x_ready_o) begin
      @(posedge clk_i);
      #1;
    end
    issue_cyc[id] = cyc + 1;
    issued[id]    = issued[id] + 1;
    @(posedge clk_i);
    #1;
    x_valid_i = 1'b0;
  endtask

  task automatic check_latency(input cvxif_pkg::id_t id, input int exp);
    tst_err += mismatch("writeback latency", 32'(seen_cyc[id] - issue_cyc[id] + 1), 32'(exp));
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %-8s : %0d errors", name, tst_err + mon_err - errs_before);
  endtask

  task automatic reset_test();
    tst_err += mismatch("x_valid_o after reset", 32'(x_valid_o), 32'd0);
    tst_err += mismatch("x_exc_valid_o after reset", 32'(x_exc_valid_o), 32'd0);
    tst_err += mismatch("x_we_o after reset", 32'(x_we_o), 32'd0);
    tst_err += mismatch("x_ready_o after reset", 32'(x_ready_o), 32'd1);
  endtask

  task automatic alu_test();
    logic [2:0] f3;
    for (int k = 0; k < 3; k++) begin
      f3 = (k == 0) ? 3'd0 : (k == 1) ? 3'd1 : 3'd3;
      issue_op(cvxif_pkg::id_t'(k + 1), make_instr(7'b0001011, f3),
               32'h1234_5678, 32'h8765_4321);
      wait_idle(cvxif_pkg::id_t'(k + 1));
      check_latency(cvxif_pkg::id_t'(k + 1), 1);
    end
  endtask

  task automatic mul_test();
    issue_op(cvxif_pkg::id_t'(5), make_instr(7'b0001011, 3'd2), 32'hFFFF_0003, 32'h0001_0005);
    // No new issue while the product is formed
    for (int k = 1; k <= `MUL_CYCLES - 2; k++) begin
      tst_err += mismatch("x_ready_o during MUL", 32'(x_ready_o), 32'd0);
      @(posedge clk_i);
      #1;
    end
    wait_idle(cvxif_pkg::id_t'(5));
    check_latency(cvxif_pkg::id_t'(5), `MUL_CYCLES);
  endtask

  task automatic illegal_test();
    logic [31:0] instr;
    for (int k = 0; k < 3; k++) begin
      instr = (k == 0) ? make_instr(7'b0110011, 3'd0) :
              (k == 1) ? make_instr(7'b0001011, 3'd5) : make_instr(7'b0001011, 3'd7);
      issue_op(cvxif_pkg::id_t'(k + 6), instr, 32'hDEAD_BEEF, 32'h0000_0011);
      wait_idle(cvxif_pkg::id_t'(k + 6));
      check_latency(cvxif_pkg::id_t'(k + 6), 1);
    end
  endtask

  task automatic stream_test();
    logic [31:0]      instr;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    int               wb_start;
    wb_start = wb_cnt;
    for (int i = 0; i < STREAM_LEN; i++) begin
      rnd   = lcg_next(rnd);
      instr = rnd;
      rnd   = lcg_next(rnd);
      a     = rnd;
      rnd   = lcg_next(rnd);
      b     = rnd;
      // Mostly custom-0 with funct3 spread over legal and illegal codes
      if (instr[31:30] != 2'b00) begin
        instr[6:0] = 7'b0001011;
      end
      issue_op(cvxif_pkg::id_t'(i), instr, a, b);
    end
    for (int k = 0; k < NUM_IDS; k++) begin
      wait_idle(cvxif_pkg::id_t'(k));
    end
    tst_err += mismatch("stream writeback count", 32'(wb_cnt - wb_start), 32'(STREAM_LEN));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    x_valid_i = 1'b0;
    x_instr_i = '0;
    x_id_i    = '0;
    x_rs1_i   = '0;
    x_rs2_i   = '0;
    rnd       = 32'd87653;
    tst_err   = 0;
    wait (rst_ni);
    @(posedge clk_i);
    #1;
    errs_start = tst_err + mon_err;
    reset_test();
    report_test("reset", errs_start);
    errs_start = tst_err + mon_err;
    alu_test();
    report_test("alu", errs_start);
    errs_start = tst_err + mon_err;
    mul_test();
    report_test("mul", errs_start);
    errs_start = tst_err + mon_err;
    illegal_test();
    report_test("illegal", errs_start);
    errs_start = tst_err + mon_err;
    stream_test();
    report_test("stream", errs_start);
    $display("summary: 5 tests, %0d writebacks, %0d errors", wb_cnt, tst_err + mon_err);
    if (tst_err + mon_err == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+hdl
hdl/cvxif_pkg.sv
hdl/hold_buf.sv
hdl/cvxif_offload.sv
hdl/xcopro.sv
hdl/cvxif_wb_merge.sv
hdl/cvxif_subsys.sv
tests/tb_clock.sv
tests/cvxif_checker.sv
tests/cvxif_tb.sv

// File: Makefile
# Verilator simulation of the CV-X-IF offload subsystem

VERILATOR ?= verilator
TOP       ?= cvxif_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
